/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= mmu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
hw/sv32_pkg.sv
hw/sv32_tlb.sv
hw/pte_check.sv
hw/walk_ctrl.sv
hw/sv32_mmu.sv
sim/tb_clock.sv
sim/page_mem.sv
sim/mmu_tb.sv

/* hw/pte_check.sv */
// Page table entry checker
// decodes one PTE, checks access rights and builds the A/D updated entry

`timescale 1ns/100ps

module pte_check (
    input  logic [sv32_pkg::XLEN-1:0]   pte,
    input  logic                        level,
    input  sv32_pkg::acc_t              acc,
    input  sv32_pkg::priv_t             priv,
    input  logic                        sum,
    input  logic                        mxr,
    output logic                        leaf,
    output logic                        fault,
    output logic                        update,
    output logic [sv32_pkg::XLEN-1:0]   pte_new
);
    import sv32_pkg::*;

    logic [2:0] perm;
    logic       bad_encoding;
    logic       user_fault;
    logic       perm_fault;
    logic       leaf_fault;
    logic       ptr_fault;
    logic [XLEN-1:0] set_mask;

    // R or X marks a leaf, otherwise the entry points to the next level
    assign leaf = pte[PTE_R] | pte[PTE_X];

    // W without R is reserved
    assign bad_encoding = pte[PTE_W] & ~pte[PTE_R];

    assign user_fault = ((priv == PRIV_S) && pte[PTE_U] && !sum) ||
                        ((priv == PRIV_U) && !pte[PTE_U]);

    // {X, W, R}, with MXR letting executable pages be read
    assign perm = {pte[PTE_X], pte[PTE_W], pte[PTE_R] | (mxr & pte[PTE_X])};
    assign perm_fault = !perm[acc];

    assign leaf_fault = leaf && (user_fault || perm_fault);

    // no third level in Sv32
    assign ptr_fault = !leaf && (level == 1'b0);

    assign fault = !pte[PTE_V] || bad_encoding || leaf_fault || ptr_fault;

    always_comb begin
        set_mask        = '0;
        set_mask[PTE_A] = 1'b1;
        if (acc == ACC_WRITE) begin
            set_mask[PTE_D] = 1'b1;
        end
    end

    assign pte_new = pte | set_mask;
    assign update  = (pte_new != pte);

endmodule

/* hw/sv32_mmu.sv */
// Sv32 MMU top level
// transaction controller, PTE checker and separate fetch, load and store TLBs

`timescale 1ns/100ps

module sv32_mmu #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                        CLK,
    input  logic                        rst_n,
    input  logic                        req,
    input  sv32_pkg::acc_t              acc,
    input  logic [sv32_pkg::XLEN-1:0]   vaddr,
    input  logic [sv32_pkg::XLEN-1:0]   wdata,
    input  sv32_pkg::size_t             size,
    input  sv32_pkg::priv_t             priv,
    input  logic [sv32_pkg::XLEN-1:0]   satp,
    input  logic                        sum,
    input  logic                        mxr,
    input  logic                        tlb_flush,
    input  logic                        mem_ack,
    input  logic [sv32_pkg::XLEN-1:0]   mem_rdata,
    output logic                        done,
    output logic [sv32_pkg::XLEN-1:0]   rdata,
    output logic                        fault,
    output sv32_pkg::cause_t            cause,
    output logic                        mem_req,
    output logic                        mem_we,
    output logic [sv32_pkg::XLEN-1:0]   mem_addr,
    output logic [sv32_pkg::XLEN-1:0]   mem_wdata,
    output sv32_pkg::size_t             mem_size
);
    import sv32_pkg::*;

    logic [2*VPN_W-1:0]     look_vpn;
    logic [2:0]             fill;
    logic [PPN_W-1:0]       fill_ppn;
    logic [2:0]             tlb_hit;
    logic [2:0][PPN_W-1:0]  tlb_ppn;
    logic [XLEN-1:0]        pte;
    logic                   level;
    logic                   pte_leaf;
    logic                   pte_fault;
    logic                   pte_update;
    logic [XLEN-1:0]        pte_new;

    walk_ctrl u_ctrl (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .req        (req),
        .acc        (acc),
        .vaddr      (vaddr),
        .wdata      (wdata),
        .size       (size),
        .priv       (priv),
        .satp       (satp),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .tlb_hit    (tlb_hit),
        .tlb_ppn    (tlb_ppn),
        .pte_leaf   (pte_leaf),
        .pte_fault  (pte_fault),
        .pte_update (pte_update),
        .pte_new    (pte_new),
        .done       (done),
        .rdata      (rdata),
        .fault      (fault),
        .cause      (cause),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_size   (mem_size),
        .look_vpn   (look_vpn),
        .fill       (fill),
        .fill_ppn   (fill_ppn),
        .pte        (pte),
        .level      (level)
    );

    pte_check u_check (
        .pte     (pte),
        .level   (level),
        .acc     (acc),
        .priv    (priv),
        .sum     (sum),
        .mxr     (mxr),
        .leaf    (pte_leaf),
        .fault   (pte_fault),
        .update  (pte_update),
        .pte_new (pte_new)
    );

    // one TLB per access type, indexed by the acc_t value
    sv32_tlb #(.ENTRIES(TLB_ENTRIES)) tlb_code (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (tlb_flush),
        .fill     (fill[ACC_CODE]),
        .fill_vpn (look_vpn),
        .fill_ppn (fill_ppn),
        .look_vpn (look_vpn),
        .hit      (tlb_hit[ACC_CODE]),
        .ppn      (tlb_ppn[ACC_CODE])
    );

    sv32_tlb #(.ENTRIES(TLB_ENTRIES)) tlb_read (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (tlb_flush),
        .fill     (fill[ACC_READ]),
        .fill_vpn (look_vpn),
        .fill_ppn (fill_ppn),
        .look_vpn (look_vpn),
        .hit      (tlb_hit[ACC_READ]),
        .ppn      (tlb_ppn[ACC_READ])
    );

    sv32_tlb #(.ENTRIES(TLB_ENTRIES)) tlb_write (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (tlb_flush),
        .fill     (fill[ACC_WRITE]),
        .fill_vpn (look_vpn),
        .fill_ppn (fill_ppn),
        .look_vpn (look_vpn),
        .hit      (tlb_hit[ACC_WRITE]),
        .ppn      (tlb_ppn[ACC_WRITE])
    );

endmodule

/* hw/sv32_pkg.sv */
// Sv32 MMU shared definitions
// access, privilege, size and cause encodings, PTE fields and widths

package sv32_pkg;

    localparam int XLEN       = 32;
    localparam int VPN_W      = 10;
    localparam int PPN_W      = 20;
    localparam int PAGE_OFS_W = 12;

    // values double as index into the {X, W, R} permission bits
    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_CODE  = 2'd2
    } acc_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } size_t;

    typedef enum logic [4:0] {
        CAUSE_NONE     = 5'd0,
        CAUSE_FETCH_PF = 5'd12,
        CAUSE_LOAD_PF  = 5'd13,
        CAUSE_STORE_PF = 5'd15
    } cause_t;

    // page table entry fields
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;

    localparam int SATP_MODE_BIT = 31;

endpackage

/* hw/sv32_tlb.sv */
// Direct-mapped TLB
// maps a virtual page number to a physical page number, cleared by flush

`timescale 1ns/100ps

module sv32_tlb #(
    parameter int ENTRIES = 16
) (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  logic                            flush,
    input  logic                            fill,
    input  logic [2*sv32_pkg::VPN_W-1:0]    fill_vpn,
    input  logic [sv32_pkg::PPN_W-1:0]      fill_ppn,
    input  logic [2*sv32_pkg::VPN_W-1:0]    look_vpn,
    output logic                            hit,
    output logic [sv32_pkg::PPN_W-1:0]      ppn
);
    import sv32_pkg::*;

    localparam int VPN_BITS = 2 * VPN_W;
    localparam int IDX_W    = $clog2(ENTRIES);
    localparam int TAG_W    = VPN_BITS - IDX_W;

    logic [ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]   tag_mem [ENTRIES];
    logic [PPN_W-1:0]   ppn_mem [ENTRIES];

    logic [IDX_W-1:0]   look_idx;
    logic [TAG_W-1:0]   look_tag;
    logic [IDX_W-1:0]   fill_idx;
    logic [TAG_W-1:0]   fill_tag;

    assign look_idx = look_vpn[IDX_W-1:0];
    assign look_tag = look_vpn[VPN_BITS-1:IDX_W];
    assign fill_idx = fill_vpn[IDX_W-1:0];
    assign fill_tag = fill_vpn[VPN_BITS-1:IDX_W];

    // lookup in the same cycle
    assign hit = valid_q[look_idx] && (tag_mem[look_idx] == look_tag);
    assign ppn = ppn_mem[look_idx];

    // flush takes priority over a fill in the same cycle
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_mem[fill_idx] <= fill_tag;
            ppn_mem[fill_idx] <= fill_ppn;
        end
    end

endmodule

/* hw/walk_ctrl.sv */
// Sv32 transaction controller
// bare pass-through, TLB lookup, two-level page walk, PTE write-back and data access

`timescale 1ns/100ps

module walk_ctrl (
    input  logic                                CLK,
    input  logic                                rst_n,
    input  logic                                req,
    input  sv32_pkg::acc_t                      acc,
    input  logic [sv32_pkg::XLEN-1:0]           vaddr,
    input  logic [sv32_pkg::XLEN-1:0]           wdata,
    input  sv32_pkg::size_t                     size,
    input  sv32_pkg::priv_t                     priv,
    input  logic [sv32_pkg::XLEN-1:0]           satp,
    input  logic                                mem_ack,
    input  logic [sv32_pkg::XLEN-1:0]           mem_rdata,
    input  logic [2:0]                          tlb_hit,
    input  logic [2:0][sv32_pkg::PPN_W-1:0]     tlb_ppn,
    input  logic                                pte_leaf,
    input  logic                                pte_fault,
    input  logic                                pte_update,
    input  logic [sv32_pkg::XLEN-1:0]           pte_new,
    output logic                                done,
    output logic [sv32_pkg::XLEN-1:0]           rdata,
    output logic                                fault,
    output sv32_pkg::cause_t                    cause,
    output logic                                mem_req,
    output logic                                mem_we,
    output logic [sv32_pkg::XLEN-1:0]           mem_addr,
    output logic [sv32_pkg::XLEN-1:0]           mem_wdata,
    output sv32_pkg::size_t                     mem_size,
    output logic [2*sv32_pkg::VPN_W-1:0]        look_vpn,
    output logic [2:0]                          fill,
    output logic [sv32_pkg::PPN_W-1:0]          fill_ppn,
    output logic [sv32_pkg::XLEN-1:0]           pte,
    output logic                                level
);
    import sv32_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WAIT_PTE,
        ST_WAIT_UPD,
        ST_WAIT_DATA
    } state_t;

    state_t         state_q, state_d;
    logic           level_q;

    // registered request
    acc_t           acc_q;
    logic [XLEN-1:0] vaddr_q;
    logic [XLEN-1:0] wdata_q;
    size_t          size_q;
    logic [XLEN-1:0] paddr_q;

    // memory port and result registers
    logic           mem_req_q;
    logic           mem_we_q;
    logic [XLEN-1:0] mem_addr_q;
    logic [XLEN-1:0] mem_wdata_q;
    size_t          mem_size_q;
    logic           done_q;
    logic           fault_q;
    cause_t         cause_q;
    logic [XLEN-1:0] rdata_q;

    logic           bare;
    logic           data_we;
    logic [XLEN-1:0] leaf_paddr;
    logic           leaf_ok;
    logic           descend;
    logic           issue;
    logic           issue_we;
    logic [XLEN-1:0] issue_addr;
    logic [XLEN-1:0] issue_wdata;
    size_t          issue_size;
    logic           finish;
    logic           finish_fault;
    cause_t         pf_cause;

    assign bare    = (priv == PRIV_M) || !satp[SATP_MODE_BIT];
    assign data_we = (acc_q == ACC_WRITE);
    assign pte     = mem_rdata;
    assign look_vpn = vaddr_q[XLEN-1:PAGE_OFS_W];

    // superpage keeps VPN[0] from the virtual address
    assign leaf_paddr = level_q ?
        {pte[PTE_PPN_LSB+PPN_W-1 -: VPN_W], vaddr_q[PAGE_OFS_W+VPN_W-1:0]} :
        {pte[PTE_PPN_LSB +: PPN_W], vaddr_q[PAGE_OFS_W-1:0]};

    assign leaf_ok  = (state_q == ST_WAIT_PTE) && mem_ack && pte_leaf && !pte_fault;
    assign descend  = (state_q == ST_WAIT_PTE) && mem_ack && !pte_leaf && !pte_fault;
    assign fill     = leaf_ok ? (3'b001 << acc_q) : 3'b000;
    assign fill_ppn = leaf_paddr[XLEN-1:PAGE_OFS_W];

    always_comb begin
        case (acc_q)
            ACC_CODE:  pf_cause = CAUSE_FETCH_PF;
            ACC_READ:  pf_cause = CAUSE_LOAD_PF;
            default:   pf_cause = CAUSE_STORE_PF;
        endcase
    end

    always_comb begin
        state_d      = state_q;
        issue        = 1'b0;
        issue_we     = data_we;
        issue_addr   = paddr_q;
        issue_wdata  = wdata_q;
        issue_size   = size_q;
        finish       = 1'b0;
        finish_fault = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (req) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                issue = 1'b1;
                if (bare) begin
                    issue_addr = vaddr_q;
                    state_d    = ST_WAIT_DATA;
                end else if (tlb_hit[acc_q]) begin
                    issue_addr = {tlb_ppn[acc_q], vaddr_q[PAGE_OFS_W-1:0]};
                    state_d    = ST_WAIT_DATA;
                end else begin
                    // level-1 PTE read from the root table
                    issue_we   = 1'b0;
                    issue_size = SIZE_W;
                    issue_addr = {satp[PPN_W-1:0], vaddr_q[XLEN-1 -: VPN_W], 2'b00};
                    state_d    = ST_WAIT_PTE;
                end
            end
            ST_WAIT_PTE: begin
                if (mem_ack) begin
                    if (pte_fault) begin
                        finish       = 1'b1;
                        finish_fault = 1'b1;
                        state_d      = ST_IDLE;
                    end else if (!pte_leaf) begin
                        issue      = 1'b1;
                        issue_we   = 1'b0;
                        issue_size = SIZE_W;
                        issue_addr = {pte[PTE_PPN_LSB +: PPN_W],
                                      vaddr_q[PAGE_OFS_W +: VPN_W], 2'b00};
                    end else if (pte_update) begin
                        // write back to the PTE just read
                        issue       = 1'b1;
                        issue_we    = 1'b1;
                        issue_size  = SIZE_W;
                        issue_addr  = mem_addr_q;
                        issue_wdata = pte_new;
                        state_d     = ST_WAIT_UPD;
                    end else begin
                        issue      = 1'b1;
                        issue_addr = leaf_paddr;
                        state_d    = ST_WAIT_DATA;
                    end
                end
            end
            ST_WAIT_UPD: begin
                if (mem_ack) begin
                    issue   = 1'b1;
                    state_d = ST_WAIT_DATA;
                end
            end
            ST_WAIT_DATA: begin
                if (mem_ack) begin
                    finish  = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            level_q   <= 1'b1;
            mem_req_q <= 1'b0;
            done_q    <= 1'b0;
            fault_q   <= 1'b0;
            cause_q   <= CAUSE_NONE;
            rdata_q   <= '0;
        end else begin
            state_q   <= state_d;
            mem_req_q <= issue;
            done_q    <= finish;
            if (state_q == ST_LOOKUP) begin
                level_q <= 1'b1;
            end else if (descend) begin
                level_q <= 1'b0;
            end
            if (finish) begin
                fault_q <= finish_fault;
                cause_q <= finish_fault ? pf_cause : CAUSE_NONE;
                rdata_q <= (finish_fault || data_we) ? '0 : mem_rdata;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == ST_IDLE && req) begin
            acc_q   <= acc;
            vaddr_q <= vaddr;
            wdata_q <= wdata;
            size_q  <= size;
        end
        if (issue) begin
            mem_we_q    <= issue_we;
            mem_addr_q  <= issue_addr;
            mem_wdata_q <= issue_wdata;
            mem_size_q  <= issue_size;
        end
        if (leaf_ok) begin
            paddr_q <= leaf_paddr;
        end
    end

    assign done      = done_q;
    assign rdata     = rdata_q;
    assign fault     = fault_q;
    assign cause     = cause_q;
    assign mem_req   = mem_req_q;
    assign mem_we    = mem_we_q;
    assign mem_addr  = mem_addr_q;
    assign mem_wdata = mem_wdata_q;
    assign mem_size  = mem_size_q;
    assign level     = level_q;

endmodule

/* sim/mmu_tb.sv */
// Sv32 MMU testbench
// builds page tables, runs bare, translated and faulting accesses, checks each

`timescale 1ns/100ps

module mmu_tb;
    import sv32_pkg::*;

    localparam int          NUM_ACCESSES      = 18;
    localparam int          CYCLES_PER_ACCESS = 40;
    localparam logic [31:0] SATP_ON  = 32'h8000_0010;
    localparam logic [31:0] ROOT     = 32'h0001_0000;
    localparam logic [31:0] L0_TABLE = 32'h0001_1000;
    localparam logic [7:0]  F_V = 8'h01;
    localparam logic [7:0]  F_R = 8'h02;
    localparam logic [7:0]  F_W = 8'h04;
    localparam logic [7:0]  F_X = 8'h08;
    localparam logic [7:0]  F_U = 8'h10;
    localparam logic [7:0]  F_A = 8'h40;
    localparam logic [7:0]  F_D = 8'h80;

    logic        CLK;
    logic        rst_n;
    logic        req;
    acc_t        acc;
    logic [31:0] vaddr;
    logic [31:0] wdata;
    size_t       size;
    priv_t       priv;
    logic [31:0] satp;
    logic        sum;
    logic        mxr;
    logic        tlb_flush;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        done;
    logic [31:0] rdata;
    logic        fault;
    cause_t      cause;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    size_t       mem_size;

    // seen at the DUT ports during the current access
    int          cyc;
    int          req_cyc;
    logic        done_seen;
    logic        got_fault;
    cause_t      got_cause;
    logic [31:0] got_rdata;
    logic [31:0] seen_addr[$];
    logic        seen_we[$];
    logic [1:0]  seen_size[$];
    logic [31:0] seen_wdata[$];
    logic [31:0] exp_addr[$];
    logic        exp_we[$];
    logic [1:0]  exp_size[$];
    logic [31:0] exp_wdata[$];

    tb_clock #(.PERIOD(100), .RESET_CYCLES(5)) clk0 (.CLK(CLK), .rst_n(rst_n));

    page_mem mem0 (
        .CLK(CLK), .rst_n(rst_n), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_size(mem_size),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    sv32_mmu #(.TLB_ENTRIES(16)) dut0 (
        .CLK(CLK), .rst_n(rst_n), .req(req), .acc(acc), .vaddr(vaddr), .wdata(wdata),
        .size(size), .priv(priv), .satp(satp), .sum(sum), .mxr(mxr),
        .tlb_flush(tlb_flush), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .done(done), .rdata(rdata), .fault(fault), .cause(cause),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_size(mem_size)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic [7:0] flags);
        return {2'b00, ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] l1_addr(input logic [31:0] va);
        return ROOT + {20'd0, va[31:22], 2'b00};
    endfunction

    function automatic logic [31:0] l0_addr(input logic [31:0] va);
        return L0_TABLE + {20'd0, va[21:12], 2'b00};
    endfunction

    // memory word read through the model's backdoor
    task automatic verify_word(input string name, input logic [31:0] addr,
                               input logic [31:0] exp);
        logic [31:0] word;
        mem0.peek_word(addr, word);
        check_value(name, word, exp);
    endtask

    task automatic expect_req(input logic [31:0] addr, input logic we,
                              input logic [1:0] sz, input logic [31:0] wd);
        exp_addr.push_back(addr);
        exp_we.push_back(we);
        exp_size.push_back(sz);
        exp_wdata.push_back(wd);
    endtask

    task automatic expect_walk(input logic [31:0] va);
        expect_req(l1_addr(va), 1'b0, SIZE_W, '0);
        expect_req(l0_addr(va), 1'b0, SIZE_W, '0);
    endtask

    // one access, then compare the memory requests against the expected list
    task automatic run_access(input acc_t a, input logic [31:0] va, input logic [31:0] wd);
        @(negedge CLK);
        acc   = a;
        vaddr = va;
        wdata = wd;
        size  = SIZE_W;
        req   = 1'b1;
        @(negedge CLK);
        req = 1'b0;
        while (!done_seen) @(negedge CLK);
        check_value("mem_req count", seen_addr.size(), exp_addr.size());
        foreach (exp_addr[i]) begin
            check_value("mem_addr", seen_addr[i], exp_addr[i]);
            check_value("mem_we", {31'd0, seen_we[i]}, {31'd0, exp_we[i]});
            check_value("mem_size", {30'd0, seen_size[i]}, {30'd0, exp_size[i]});
            if (exp_we[i]) begin
                check_value("mem_wdata", seen_wdata[i], exp_wdata[i]);
            end
        end
        exp_addr.delete();
        exp_we.delete();
        exp_size.delete();
        exp_wdata.delete();
    endtask

    task automatic check_result(input logic f, input cause_t c, input logic [31:0] rd);
        check_value("fault", {31'd0, got_fault}, {31'd0, f});
        check_value("cause", {27'd0, got_cause}, {27'd0, c});
        check_value("rdata", got_rdata, rd);
    endtask

    // successful read that returns the word held by the memory model
    task automatic verify_load(input logic [31:0] addr);
        logic [31:0] word;
        mem0.peek_word(addr, word);
        check_result(1'b0, CAUSE_NONE, word);
    endtask

    // sampled on the rising edge, before the DUT registers update
    always @(posedge CLK) begin
        if (req) begin
            req_cyc   = cyc;
            done_seen = 1'b0;
            seen_addr.delete();
            seen_we.delete();
            seen_size.delete();
            seen_wdata.delete();
        end
        if (mem_req) begin
            if (seen_addr.size() == 0) begin
                assert (cyc == req_cyc + 2)
                else fail_run("first memory request did not come 2 cycles after req");
            end
            seen_addr.push_back(mem_addr);
            seen_we.push_back(mem_we);
            seen_size.push_back(mem_size);
            seen_wdata.push_back(mem_wdata);
        end
        if (done) begin
            done_seen = 1'b1;
            got_fault = fault;
            got_cause = cause;
            got_rdata = rdata;
        end
        cyc = cyc + 1;
    end

    initial begin
        #((NUM_ACCESSES * CYCLES_PER_ACCESS + 20) * 100);
        $display("watchdog expired before all accesses completed");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] va;
        logic [31:0] pa;
        cyc       = 0;
        req_cyc   = 0;
        done_seen = 1'b0;
        req       = 1'b0;
        acc       = ACC_READ;
        vaddr     = '0;
        wdata     = '0;
        size      = SIZE_W;
        priv      = PRIV_M;
        satp      = SATP_ON;
        sum       = 1'b0;
        mxr       = 1'b0;
        tlb_flush = 1'b0;
        @(posedge rst_n);
        check_value("mem_req after reset", {31'd0, mem_req}, 32'd0);
        check_value("done after reset", {31'd0, done}, 32'd0);
        check_value("fault after reset", {31'd0, fault}, 32'd0);

        // root: pointer for VPN[1]=1, 4 MiB superpage at VPN[1]=2
        mem0.load_word(ROOT + 32'd4, make_pte(20'h00011, F_V));
        mem0.load_word(ROOT + 32'd8, make_pte(20'h00000, F_V | F_R | F_W | F_A | F_D));
        mem0.load_word(L0_TABLE + 32'd0, make_pte(20'h00020, F_V | F_R | F_W));
        mem0.load_word(L0_TABLE + 32'd4, make_pte(20'h00021, F_R | F_A));
        mem0.load_word(L0_TABLE + 32'd8, make_pte(20'h00022, F_V | F_W | F_A));
        mem0.load_word(L0_TABLE + 32'd12, make_pte(20'h00023, F_V | F_R | F_U | F_A));
        mem0.load_word(L0_TABLE + 32'd16, make_pte(20'h00024, F_V | F_R | F_A));
        mem0.load_word(L0_TABLE + 32'd20, make_pte(20'h00025, F_V | F_R | F_W | F_A | F_D));
        mem0.load_word(L0_TABLE + 32'd24, make_pte(20'h00026, F_V | F_X | F_A));

        // bare mode, M-mode then satp mode 0
        va = 32'h0000_3004;
        expect_req(va, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va, '0);
        verify_load(va);
        priv = PRIV_S;
        satp = 32'd0;
        va   = 32'h0000_3108;
        expect_req(va, 1'b1, SIZE_W, 32'h1234_5678);
        run_access(ACC_WRITE, va, 32'h1234_5678);
        check_result(1'b0, CAUSE_NONE, '0);
        expect_req(va, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va, '0);
        check_result(1'b0, CAUSE_NONE, 32'h1234_5678);

        // 4 KiB page with A clear, then a TLB hit
        satp = SATP_ON;
        va   = 32'h0040_0010;
        pa   = {20'h00020, va[11:0]};
        expect_walk(va);
        expect_req(l0_addr(va), 1'b1, SIZE_W, make_pte(20'h00020, F_V | F_R | F_W | F_A));
        expect_req(pa, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va, '0);
        verify_load(pa);
        expect_req(pa + 32'd4, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va + 32'd4, '0);
        verify_load(pa + 32'd4);

        // superpage keeps VPN[0] and the offset
        va = 32'h0080_9040;
        pa = {10'd0, va[21:0]};
        expect_req(l1_addr(va), 1'b0, SIZE_W, '0);
        expect_req(pa, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va, '0);
        verify_load(pa);
        expect_req(pa, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va, '0);
        verify_load(pa);

        // store misses the store TLB and sets D
        va = 32'h0040_0010;
        pa = {20'h00020, va[11:0]};
        expect_walk(va);
        expect_req(l0_addr(va), 1'b1, SIZE_W,
                   make_pte(20'h00020, F_V | F_R | F_W | F_A | F_D));
        expect_req(pa, 1'b1, SIZE_W, 32'hCAFE_F00D);
        run_access(ACC_WRITE, va, 32'hCAFE_F00D);
        check_result(1'b0, CAUSE_NONE, '0);
        verify_word("pte", l0_addr(va), make_pte(20'h00020, F_V | F_R | F_W | F_A | F_D));
        verify_word("stored word", pa, 32'hCAFE_F00D);

        // faults end after the deciding PTE read
        expect_walk(32'h0040_1000);
        run_access(ACC_READ, 32'h0040_1000, '0);
        check_result(1'b1, CAUSE_LOAD_PF, '0);
        expect_walk(32'h0040_2000);
        run_access(ACC_WRITE, 32'h0040_2000, 32'h0F0F_3C3C);
        check_result(1'b1, CAUSE_STORE_PF, '0);
        expect_walk(32'h0040_3000);
        run_access(ACC_READ, 32'h0040_3000, '0);
        check_result(1'b1, CAUSE_LOAD_PF, '0);
        sum = 1'b1;
        expect_walk(32'h0040_3000);
        expect_req(32'h0002_3000, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, 32'h0040_3000, '0);
        verify_load(32'h0002_3000);
        sum = 1'b0;
        expect_walk(32'h0040_4000);
        run_access(ACC_WRITE, 32'h0040_4000, 32'h5555_AAAA);
        check_result(1'b1, CAUSE_STORE_PF, '0);
        expect_walk(32'h0040_5000);
        run_access(ACC_CODE, 32'h0040_5000, '0);
        check_result(1'b1, CAUSE_FETCH_PF, '0);
        expect_walk(32'h0040_6000);
        run_access(ACC_READ, 32'h0040_6000, '0);
        check_result(1'b1, CAUSE_LOAD_PF, '0);
        mxr = 1'b1;
        expect_walk(32'h0040_6000);
        expect_req(32'h0002_6000, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, 32'h0040_6000, '0);
        verify_load(32'h0002_6000);
        mxr = 1'b0;

        // load hit, then flush forces a new walk
        va = 32'h0040_0010;
        pa = {20'h00020, va[11:0]};
        expect_req(pa, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va, '0);
        check_result(1'b0, CAUSE_NONE, 32'hCAFE_F00D);
        @(negedge CLK);
        tlb_flush = 1'b1;
        @(negedge CLK);
        tlb_flush = 1'b0;
        expect_walk(va);
        expect_req(pa, 1'b0, SIZE_W, '0);
        run_access(ACC_READ, va, '0);
        check_result(1'b0, CAUSE_NONE, 32'hCAFE_F00D);

        $display("all tests passed");
        $finish;
    end

endmodule

/* sim/page_mem.sv */
// Word memory model for the MMU memory port
// random acknowledge latency of 1 to 4 cycles, backdoor load and peek

`timescale 1ns/100ps

module page_mem (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [1:0]  mem_size,
    output logic        mem_ack,
    output logic [31:0] mem_rdata
);
    logic [31:0] mem [0:65535];
    integer      seed;
    logic        pending;
    int          wait_cnt;
    logic        we_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [1:0]  size_q;

    // pattern built from the whole byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'hC3D2_E1F0;
    endfunction

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[17:2]] = data;
    endtask

    task automatic peek_word(input logic [31:0] addr, output logic [31:0] data);
        data = mem[addr[17:2]];
    endtask

    initial begin
        seed      = 57;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        pending   = 1'b0;
        wait_cnt  = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = fill_word({14'd0, i[15:0], 2'b00});
        end
    end

    // outputs change on the falling edge, away from the DUT sampling edge
    always @(negedge CLK) begin
        logic [31:0] word;
        mem_ack = 1'b0;
        if (!rst_n) begin
            pending = 1'b0;
        end else begin
            if (pending) begin
                if (wait_cnt == 0) begin
                    word = mem[addr_q[17:2]];
                    if (we_q) begin
                        case (size_q)
                            2'd0: word[8*addr_q[1:0] +: 8] = wdata_q[7:0];
                            2'd1: word[16*addr_q[1] +: 16] = wdata_q[15:0];
                            default: word = wdata_q;
                        endcase
                        mem[addr_q[17:2]] = word;
                        mem_rdata = '0;
                    end else begin
                        mem_rdata = word;
                    end
                    mem_ack = 1'b1;
                    pending = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
            if (mem_req) begin
                pending  = 1'b1;
                wait_cnt = int'($unsigned($random(seed)) % 32'd4);
                we_q     = mem_we;
                addr_q   = mem_addr;
                wdata_q  = mem_wdata;
                size_q   = mem_size;
            end
        end
    end

endmodule

/* sim/tb_clock.sv */
// Testbench clock and reset generator

`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic CLK,
    output logic rst_n
);
    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // release reset on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
    end

endmodule
